// ==== bus_arbiter.sv ====
// combines slot decode with the bus strobes into memory strobes, cpu read data and external mreq
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                              mapper_sel,
    input  logic                              exp_reg_sel,
    input  logic [msx_bus_pkg::DATA_W-1:0]    exp_reg_rdata,
    input  logic                              bus_mreq_n,
    input  logic                              bus_rd_n,
    input  logic                              bus_wr_n,
    input  logic [msx_bus_pkg::DATA_W-1:0]    mem_rdata,
    input  logic [msx_bus_pkg::DATA_W-1:0]    ext_rdata,
    output logic                              mem_rd,
    output logic                              mem_wr,
    output logic                              ext_mreq_n,
    output logic [msx_bus_pkg::DATA_W-1:0]    cpu_rdata
);

    logic exp_reg_rd;   // cpu reading FFFFh in slot 3
    logic board_rd;     // any read the board answers itself

    // -------------------------------------------------------------------------
    // direction
    // -------------------------------------------------------------------------
    assign mem_rd     = mapper_sel && !bus_rd_n;
    assign mem_wr     = mapper_sel && !bus_wr_n;
    assign exp_reg_rd = exp_reg_sel && !bus_rd_n;

    assign board_rd = mem_rd || exp_reg_rd;

    // -------------------------------------------------------------------------
    // external request
    // -------------------------------------------------------------------------

    // writes still go out, a cartridge may shadow the mapper
    always_comb begin
        if (board_rd) begin
            ext_mreq_n = 1'b1;          // keep slot bus quiet
        end else begin
            ext_mreq_n = bus_mreq_n;
        end
    end

    // -------------------------------------------------------------------------
    // read data
    // -------------------------------------------------------------------------
    always_comb begin
        if (exp_reg_rd) begin
            cpu_rdata = exp_reg_rdata;
        end else if (mem_rd) begin
            cpu_rdata = mem_rdata;      // memory answers in the same cycle
        end else begin
            cpu_rdata = ext_rdata;      // i/o and other slots
        end
    end

endmodule

// ==== mapper_pages.sv ====
// memory mapper segment registers at FCh-FFh and the cpu to 22-bit address translation
`timescale 1ns/100ps

module mapper_pages (
    input  logic                                  bus_clk_3m6,
    input  logic                                  bus_reset_n,
    input  msx_bus_pkg::bus_addr_t                bus_addr,
    input  logic                                  bus_iorq_n,
    input  logic                                  bus_wr_n,
    input  logic [msx_bus_pkg::DATA_W-1:0]        cpu_wdata,
    output logic [msx_bus_pkg::MEM_ADDR_W-1:0]    mem_addr
);

    logic [msx_bus_pkg::SEGMENT_W-1:0] seg_q [4];   // one per 16 kB page
    logic                              seg_wr;
    logic [1:0]                        seg_idx;

    // -------------------------------------------------------------------------
    // segment register write
    // -------------------------------------------------------------------------
    assign seg_wr  = !bus_iorq_n && !bus_wr_n &&
                     (bus_addr.io.port[7:2] == msx_bus_pkg::MAPPER_PORT_HI);
    assign seg_idx = bus_addr.io.port[1:0];         // FCh is page 0

    always_ff @(posedge bus_clk_3m6 or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            seg_q[0] <= msx_bus_pkg::MAPPER_RESET_SEG0;
            seg_q[1] <= msx_bus_pkg::MAPPER_RESET_SEG1;
            seg_q[2] <= msx_bus_pkg::MAPPER_RESET_SEG2;
            seg_q[3] <= msx_bus_pkg::MAPPER_RESET_SEG3;
        end else if (seg_wr) begin
            case (seg_idx)
                2'd0:    seg_q[0] <= cpu_wdata;
                2'd1:    seg_q[1] <= cpu_wdata;
                2'd2:    seg_q[2] <= cpu_wdata;
                default: seg_q[3] <= cpu_wdata;
            endcase
        end
    end

    // -------------------------------------------------------------------------
    // address translation
    // -------------------------------------------------------------------------

    // the segment replaces a15..a14, offset passes through untouched
    always_comb begin
        mem_addr = {seg_q[bus_addr.mem.page], bus_addr.mem.offset};
    end

endmodule

// ==== msx_bus_pkg.sv ====
// shared bus widths, port numbers, reset segments and the cpu address union for the slot glue
package msx_bus_pkg;

    // -------------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------------
    localparam int DATA_W        = 8;
    localparam int PAGE_OFFSET_W = 14;                          // 16 kB pages
    localparam int SEGMENT_W     = 8;
    localparam int MEM_ADDR_W    = SEGMENT_W + PAGE_OFFSET_W;   // 4 MB mapper space

    // -------------------------------------------------------------------------
    // i/o ports and fixed addresses
    // -------------------------------------------------------------------------
    localparam logic [7:0]  PPI_PORT_A     = 8'hA8;     // primary slot register
    localparam logic [5:0]  MAPPER_PORT_HI = 6'b111111; // FCh..FFh, low two bits pick page
    localparam logic [15:0] EXP_SLOT_ADDR  = 16'hFFFF;  // sub-slot register of slot 3

    // slot layout of the board
    localparam logic [1:0] EXPANDED_PRI_SLOT = 2'd3;
    localparam logic [1:0] MAPPER_PRI_SLOT   = 2'd3;
    localparam logic [1:0] MAPPER_SUB_SLOT   = 2'd3;

    // segments loaded at reset, page 0 gets the highest one
    localparam logic [SEGMENT_W-1:0] MAPPER_RESET_SEG0 = 8'd3;
    localparam logic [SEGMENT_W-1:0] MAPPER_RESET_SEG1 = 8'd2;
    localparam logic [SEGMENT_W-1:0] MAPPER_RESET_SEG2 = 8'd1;
    localparam logic [SEGMENT_W-1:0] MAPPER_RESET_SEG3 = 8'd0;

    // -------------------------------------------------------------------------
    // cpu address, seen as a memory word or as an i/o word
    // -------------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [1:0]               page;     // a15..a14
            logic [PAGE_OFFSET_W-1:0] offset;   // a13..a0
        } mem;
        struct packed {
            logic [7:0] hi;                     // b register on in/out (c)
            logic [7:0] port;
        } io;
    } bus_addr_t;

endpackage

// ==== msx_slot_mapper_checker.sv ====
// concurrent checks on the memory strobes and the external request, bound into bus_arbiter
`timescale 1ns/100ps

module msx_slot_mapper_checker (
    input logic bus_clk_3m6,
    input logic bus_reset_n,
    input logic bus_mreq_n,
    input logic mem_rd,
    input logic mem_wr,
    input logic ext_mreq_n
);

    int assert_fail_count = 0;  // failures seen so far, polled from outside

    // -------------------------------------------------------------------------
    // properties
    // -------------------------------------------------------------------------
    property rd_wr_exclusive;
        @(posedge bus_clk_3m6) disable iff (!bus_reset_n)
            !(mem_rd && mem_wr);
    endproperty

    // the board answers mapper reads, slot bus stays quiet
    property rd_hides_ext_mreq;
        @(posedge bus_clk_3m6) disable iff (!bus_reset_n)
            mem_rd |-> ext_mreq_n;
    endproperty

    property wr_passes_ext_mreq;
        @(posedge bus_clk_3m6) disable iff (!bus_reset_n)
            mem_wr |-> (ext_mreq_n == bus_mreq_n);
    endproperty

    property idle_no_strobes;
        @(posedge bus_clk_3m6) disable iff (!bus_reset_n)
            bus_mreq_n |-> (!mem_rd && !mem_wr);
    endproperty

    // -------------------------------------------------------------------------
    // assertions
    // -------------------------------------------------------------------------
    a_rd_wr_exclusive: assert property (rd_wr_exclusive) else begin
        assert_fail_count++;
        $error("mem_rd and mem_wr high in the same cycle");
    end

    a_rd_hides_ext_mreq: assert property (rd_hides_ext_mreq) else begin
        assert_fail_count++;
        $error("ext_mreq_n low during a mapper read");
    end

    a_wr_passes_ext_mreq: assert property (wr_passes_ext_mreq) else begin
        assert_fail_count++;
        $error("ext_mreq_n does not follow bus_mreq_n during a mapper write");
    end

    a_idle_no_strobes: assert property (idle_no_strobes) else begin
        assert_fail_count++;
        $error("memory strobe active without bus_mreq_n");
    end

endmodule

// ==== msx_slot_mapper_top.sv ====
// top of the slot and memory mapper glue, connects slot decode, mapper and arbiter
`timescale 1ns/100ps

module msx_slot_mapper_top (
    input  logic                                  bus_clk_3m6,
    input  logic                                  bus_reset_n,
    input  msx_bus_pkg::bus_addr_t                bus_addr,
    input  logic                                  bus_mreq_n,
    input  logic                                  bus_iorq_n,
    input  logic                                  bus_rd_n,
    input  logic                                  bus_wr_n,
    input  logic [msx_bus_pkg::DATA_W-1:0]        cpu_wdata,
    input  logic [msx_bus_pkg::DATA_W-1:0]        ext_rdata,
    input  logic [msx_bus_pkg::DATA_W-1:0]        mem_rdata,
    output logic [msx_bus_pkg::DATA_W-1:0]        cpu_rdata,
    output logic                                  ext_mreq_n,
    output logic [msx_bus_pkg::MEM_ADDR_W-1:0]    mem_addr,
    output logic                                  mem_rd,
    output logic                                  mem_wr
);

    logic                           mapper_sel;
    logic                           exp_reg_sel;
    logic [msx_bus_pkg::DATA_W-1:0] exp_reg_rdata;

    slot_select u_slot_select (
        .bus_clk_3m6   (bus_clk_3m6),
        .bus_reset_n   (bus_reset_n),
        .bus_addr      (bus_addr),
        .bus_mreq_n    (bus_mreq_n),
        .bus_iorq_n    (bus_iorq_n),
        .bus_wr_n      (bus_wr_n),
        .cpu_wdata     (cpu_wdata),
        .mapper_sel    (mapper_sel),
        .exp_reg_sel   (exp_reg_sel),
        .exp_reg_rdata (exp_reg_rdata)
    );

    mapper_pages u_mapper_pages (
        .bus_clk_3m6 (bus_clk_3m6),
        .bus_reset_n (bus_reset_n),
        .bus_addr    (bus_addr),
        .bus_iorq_n  (bus_iorq_n),
        .bus_wr_n    (bus_wr_n),
        .cpu_wdata   (cpu_wdata),
        .mem_addr    (mem_addr)
    );

    bus_arbiter u_bus_arbiter (
        .mapper_sel    (mapper_sel),
        .exp_reg_sel   (exp_reg_sel),
        .exp_reg_rdata (exp_reg_rdata),
        .bus_mreq_n    (bus_mreq_n),
        .bus_rd_n      (bus_rd_n),
        .bus_wr_n      (bus_wr_n),
        .mem_rdata     (mem_rdata),
        .ext_rdata     (ext_rdata),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr),
        .ext_mreq_n    (ext_mreq_n),
        .cpu_rdata     (cpu_rdata)
    );

endmodule

// ==== slot_select.sv ====
// primary and expanded slot registers, decodes accesses to the mapper and to FFFFh
`timescale 1ns/100ps

module slot_select (
    input  logic                              bus_clk_3m6,
    input  logic                              bus_reset_n,
    input  msx_bus_pkg::bus_addr_t            bus_addr,
    input  logic                              bus_mreq_n,
    input  logic                              bus_iorq_n,
    input  logic                              bus_wr_n,
    input  logic [msx_bus_pkg::DATA_W-1:0]    cpu_wdata,
    output logic                              mapper_sel,
    output logic                              exp_reg_sel,
    output logic [msx_bus_pkg::DATA_W-1:0]    exp_reg_rdata
);

    logic [msx_bus_pkg::DATA_W-1:0] pri_slot_q;  // ppi port a, two bits per page
    logic [msx_bus_pkg::DATA_W-1:0] exp_slot_q;  // sub-slots of slot 3
    logic [1:0]                     pri_slot;
    logic [1:0]                     sub_slot;
    logic                           pri_wr;
    logic                           exp_wr;
    logic                           at_exp_addr;
    logic                           in_exp_slot;

    // two-bit slot field of a page
    function automatic logic [1:0] page_field(
        input logic [msx_bus_pkg::DATA_W-1:0] slot_reg,
        input logic [1:0]                     page
    );
        logic [1:0] field;
        case (page)
            2'd0:    field = slot_reg[1:0];
            2'd1:    field = slot_reg[3:2];
            2'd2:    field = slot_reg[5:4];
            default: field = slot_reg[7:6];
        endcase
        return field;
    endfunction

    // -------------------------------------------------------------------------
    // decode
    // -------------------------------------------------------------------------
    assign pri_slot    = page_field(pri_slot_q, bus_addr.mem.page);
    assign sub_slot    = page_field(exp_slot_q, bus_addr.mem.page);
    assign in_exp_slot = (pri_slot == msx_bus_pkg::EXPANDED_PRI_SLOT);
    assign at_exp_addr = (bus_addr == msx_bus_pkg::EXP_SLOT_ADDR);

    assign pri_wr = !bus_iorq_n && !bus_wr_n && (bus_addr.io.port == msx_bus_pkg::PPI_PORT_A);

    // FFFFh lives in page 3, so pri_slot already is page 3's slot here
    assign exp_reg_sel = !bus_mreq_n && at_exp_addr && in_exp_slot;
    assign exp_wr      = exp_reg_sel && !bus_wr_n;

    // slot 3-3, everything but the sub-slot register itself
    assign mapper_sel = !bus_mreq_n && !at_exp_addr && in_exp_slot &&
                        (pri_slot == msx_bus_pkg::MAPPER_PRI_SLOT) &&
                        (sub_slot == msx_bus_pkg::MAPPER_SUB_SLOT);

    assign exp_reg_rdata = ~exp_slot_q;   // reads back inverted, as on real hardware

    // -------------------------------------------------------------------------
    // registers
    // -------------------------------------------------------------------------
    always_ff @(posedge bus_clk_3m6 or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            pri_slot_q <= '0;
        end else if (pri_wr) begin
            pri_slot_q <= cpu_wdata;
        end
    end

    always_ff @(posedge bus_clk_3m6 or negedge bus_reset_n) begin
        if (!bus_reset_n) begin
            exp_slot_q <= '0;
        end else if (exp_wr) begin
            exp_slot_q <= cpu_wdata;
        end
    end

endmodule

// ==== sources.f ====
msx_bus_pkg.sv
slot_select.sv
mapper_pages.sv
bus_arbiter.sv
msx_slot_mapper_top.sv
msx_slot_mapper_checker.sv
tb_msx_slot_mapper.sv

// ==== tb_msx_slot_mapper.sv ====
// testbench for the slot and mapper glue that checks lfsr stimulus against a reference model
`timescale 1ns/100ps

module tb_msx_slot_mapper;

    localparam int          CLK_PERIOD   = 40;
    localparam int          DRIVE_DELAY  = 2;       // after the rising edge
    localparam int          SAMPLE_LEAD  = 2;       // before the rising edge
    localparam int          RESET_CYCLES = 2;
    localparam logic [15:0] LFSR_SEED    = 16'd28118;

    // transactions per test
    localparam int N_DEFAULT_READS = 16;
    localparam int N_MAPPER_ACC    = 64;
    localparam int N_EXP_LOOPS     = 8;     // 8 bus cycles each
    localparam int N_SEG_ROUNDS    = 4;
    localparam int N_SEG_READS     = 24;
    localparam int N_LAYOUTS       = 16;
    localparam int N_LAYOUT_ACC    = 16;

    localparam int TOTAL_TXNS = RESET_CYCLES + N_DEFAULT_READS + 2 + N_MAPPER_ACC
                              + 8 * N_EXP_LOOPS + N_SEG_ROUNDS * (4 + N_SEG_READS)
                              + N_LAYOUTS * (3 + N_LAYOUT_ACC) + 2;
    localparam int WATCHDOG_NS = TOTAL_TXNS * CLK_PERIOD * 4;

    logic                                 bus_clk_3m6;
    logic                                 bus_reset_n;
    msx_bus_pkg::bus_addr_t               bus_addr;
    logic                                 bus_mreq_n;
    logic                                 bus_iorq_n;
    logic                                 bus_rd_n;
    logic                                 bus_wr_n;
    logic [msx_bus_pkg::DATA_W-1:0]       cpu_wdata;
    logic [msx_bus_pkg::DATA_W-1:0]       ext_rdata;
    logic [msx_bus_pkg::DATA_W-1:0]       mem_rdata;
    logic [msx_bus_pkg::DATA_W-1:0]       cpu_rdata;
    logic                                 ext_mreq_n;
    logic [msx_bus_pkg::MEM_ADDR_W-1:0]   mem_addr;
    logic                                 mem_rd;
    logic                                 mem_wr;

    logic [15:0] lfsr_q;
    logic [7:0]  ref_pri;           // model of ppi port a
    logic [7:0]  ref_exp;           // model of the FFFFh register before inversion
    logic [7:0]  ref_seg [4];
    int          txn_count;
    int          checks_done;

    msx_slot_mapper_top u_dut (
        .bus_clk_3m6 (bus_clk_3m6),
        .bus_reset_n (bus_reset_n),
        .bus_addr    (bus_addr),
        .bus_mreq_n  (bus_mreq_n),
        .bus_iorq_n  (bus_iorq_n),
        .bus_rd_n    (bus_rd_n),
        .bus_wr_n    (bus_wr_n),
        .cpu_wdata   (cpu_wdata),
        .ext_rdata   (ext_rdata),
        .mem_rdata   (mem_rdata),
        .cpu_rdata   (cpu_rdata),
        .ext_mreq_n  (ext_mreq_n),
        .mem_addr    (mem_addr),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr)
    );

    bind bus_arbiter msx_slot_mapper_checker u_checker (
        .bus_clk_3m6 (tb_msx_slot_mapper.bus_clk_3m6),
        .bus_reset_n (tb_msx_slot_mapper.bus_reset_n),
        .bus_mreq_n  (bus_mreq_n),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .ext_mreq_n  (ext_mreq_n)
    );

    always #(CLK_PERIOD / 2) bus_clk_3m6 = ~bus_clk_3m6;

    // -------------------------------------------------------------------------
    // random numbers and reference model
    // -------------------------------------------------------------------------

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit
    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] value;
        logic        fb;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            value  = {value[14:0], fb};
        end
        return value;
    endfunction

    function automatic logic [1:0] slot_of_page(input logic [7:0] slot_reg, input logic [1:0] page);
        logic [7:0] shifted;
        shifted = slot_reg >> (2 * page);
        return shifted[1:0];
    endfunction

    // {cpu_rdata, ext_mreq_n, mem_addr, mem_rd, mem_wr}
    function automatic logic [32:0] expected_outputs(
        input logic [15:0] addr,
        input logic        mreq_n,
        input logic        rd_n,
        input logic        wr_n,
        input logic [7:0]  mem_data,
        input logic [7:0]  ext_data
    );
        logic [1:0]  page;
        logic [1:0]  pri;
        logic [1:0]  sub;
        logic        exp_sel;
        logic        map_sel;
        logic        rd;
        logic        wr;
        logic        exp_rd;
        logic        mreq_out;
        logic [7:0]  rdata;
        logic [21:0] addr_out;
        page     = addr[15:14];
        pri      = slot_of_page(ref_pri, page);
        sub      = slot_of_page(ref_exp, page);
        exp_sel  = !mreq_n && (addr == 16'hFFFF) && (pri == 2'd3);
        map_sel  = !mreq_n && (addr != 16'hFFFF) && (pri == 2'd3) && (sub == 2'd3);
        rd       = map_sel && !rd_n;
        wr       = map_sel && !wr_n;
        exp_rd   = exp_sel && !rd_n;
        mreq_out = (rd || exp_rd) ? 1'b1 : mreq_n;
        if (exp_rd) begin
            rdata = ~ref_exp;
        end else if (rd) begin
            rdata = mem_data;
        end else begin
            rdata = ext_data;
        end
        addr_out = {ref_seg[page], addr[13:0]};
        return {rdata, mreq_out, addr_out, rd, wr};
    endfunction

    task automatic reset_model();
        ref_pri    = 8'h00;
        ref_exp    = 8'h00;
        ref_seg[0] = 8'd3;
        ref_seg[1] = 8'd2;
        ref_seg[2] = 8'd1;
        ref_seg[3] = 8'd0;
    endtask

    // register writes that the coming rising edge will take
    task automatic update_model();
        if (!bus_mreq_n && !bus_wr_n && bus_addr == 16'hFFFF &&
            slot_of_page(ref_pri, 2'd3) == 2'd3) begin
            ref_exp = cpu_wdata;
        end
        if (!bus_iorq_n && !bus_wr_n) begin
            if (bus_addr.io.port == 8'hA8) begin
                ref_pri = cpu_wdata;
            end
            if (bus_addr.io.port[7:2] == 6'b111111) begin
                ref_seg[bus_addr.io.port[1:0]] = cpu_wdata;
            end
        end
    endtask

    // -------------------------------------------------------------------------
    // compare
    // -------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, got, want);
            $display("Simulation failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_outputs();
        logic [32:0] want;
        want = expected_outputs(bus_addr, bus_mreq_n, bus_rd_n, bus_wr_n, mem_rdata, ext_rdata);
        check_value("cpu_rdata", 32'(cpu_rdata), 32'(want[32:25]));
        check_value("ext_mreq_n", 32'(ext_mreq_n), 32'(want[24]));
        check_value("mem_addr", 32'(mem_addr), 32'(want[23:2]));
        check_value("mem_rd", 32'(mem_rd), 32'(want[1]));
        check_value("mem_wr", 32'(mem_wr), 32'(want[0]));
        checks_done++;
    endtask

    initial begin
        reset_model();
        forever begin
            @(posedge bus_clk_3m6);
            #(CLK_PERIOD - SAMPLE_LEAD);
            if (!bus_reset_n) begin
                reset_model();
            end
            compare_outputs();
            if (u_dut.u_bus_arbiter.u_checker.assert_fail_count != 0) begin
                $display("ERROR: a bound assertion on bus_arbiter failed before %0t ns", $time);
                $display("Simulation failed");
                $fatal(1, "assertion failure");
            end
            if (bus_reset_n) begin
                update_model();
            end
        end
    end

    // -------------------------------------------------------------------------
    // bus cycles
    // -------------------------------------------------------------------------
    task automatic drive_cycle(
        input logic [15:0] addr,
        input logic        mreq_n,
        input logic        iorq_n,
        input logic        rd_n,
        input logic        wr_n,
        input logic [7:0]  wdata
    );
        @(posedge bus_clk_3m6);
        #(DRIVE_DELAY);
        bus_addr   = addr;
        bus_mreq_n = mreq_n;
        bus_iorq_n = iorq_n;
        bus_rd_n   = rd_n;
        bus_wr_n   = wr_n;
        cpu_wdata  = wdata;
        mem_rdata  = 8'(rand_bits(8));  // fresh data so the mux choice shows
        ext_rdata  = 8'(rand_bits(8));
        txn_count++;
    endtask

    task automatic mem_read(input logic [15:0] addr);
        drive_cycle(addr, 1'b0, 1'b1, 1'b0, 1'b1, 8'(rand_bits(8)));
    endtask

    task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
        drive_cycle(addr, 1'b0, 1'b1, 1'b1, 1'b0, data);
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        drive_cycle({8'(rand_bits(8)), port}, 1'b1, 1'b0, 1'b1, 1'b0, data);
    endtask

    task automatic idle_cycle(input logic [15:0] addr);
        drive_cycle(addr, 1'b1, 1'b1, 1'b1, 1'b1, 8'(rand_bits(8)));
    endtask

    // -------------------------------------------------------------------------
    // tests
    // -------------------------------------------------------------------------
    task automatic reset_defaults();
        int i;
        for (i = 0; i < N_DEFAULT_READS; i++) begin
            mem_read(rand_bits(16));
        end
    endtask

    task automatic mapper_access();
        logic [15:0] addr;
        int          i;
        io_write(msx_bus_pkg::PPI_PORT_A, 8'hFF);
        mem_write(16'hFFFF, 8'hFF);
        for (i = 0; i < N_MAPPER_ACC; i++) begin
            addr = rand_bits(16);
            if (addr == 16'hFFFF) begin
                addr = 16'hFFFE;
            end
            if (rand_bits(1) == 16'd1) begin
                mem_write(addr, 8'(rand_bits(8)));
            end else begin
                mem_read(addr);
            end
        end
    endtask

    task automatic exp_readback();
        logic [7:0] value;
        logic [1:0] other;
        int         i;
        for (i = 0; i < N_EXP_LOOPS; i++) begin
            value = 8'(rand_bits(8));
            other = 2'(rand_bits(2) % 3);   // any slot but 3
            io_write(msx_bus_pkg::PPI_PORT_A, {2'b11, 6'(rand_bits(6))});
            mem_write(16'hFFFF, value);
            mem_read(16'hFFFF);
            io_write(msx_bus_pkg::PPI_PORT_A, {other, 6'(rand_bits(6))});
            mem_read(16'hFFFF);                     // now from the slot bus
            mem_write(16'hFFFF, 8'(rand_bits(8)));  // ignored outside slot 3
            io_write(msx_bus_pkg::PPI_PORT_A, 8'hFF);
            mem_read(16'hFFFF);
        end
    endtask

    task automatic segment_writes();
        int r;
        int p;
        int i;
        for (r = 0; r < N_SEG_ROUNDS; r++) begin
            for (p = 0; p < 4; p++) begin
                io_write(8'hFC + 8'(p), 8'(rand_bits(8)));
            end
            for (i = 0; i < N_SEG_READS; i++) begin
                mem_read(rand_bits(16));
            end
        end
    endtask

    task automatic random_layouts();
        logic [15:0] addr;
        logic [1:0]  op;
        int          l;
        int          i;
        for (l = 0; l < N_LAYOUTS; l++) begin
            io_write(msx_bus_pkg::PPI_PORT_A, 8'hC0 | 8'(rand_bits(8)));
            mem_write(16'hFFFF, 8'(rand_bits(8)));
            io_write(msx_bus_pkg::PPI_PORT_A, 8'(rand_bits(8)));
            for (i = 0; i < N_LAYOUT_ACC; i++) begin
                op   = 2'(rand_bits(2));
                addr = rand_bits(16);
                case (op)
                    2'd0:    mem_read(addr);
                    2'd1:    mem_write(addr, 8'(rand_bits(8)));
                    2'd2:    mem_read(16'hFFFF);
                    default: idle_cycle(addr);
                endcase
            end
        end
    endtask

    initial begin
        bus_clk_3m6 = 1'b0;
        bus_reset_n = 1'b0;
        bus_addr    = '0;
        bus_mreq_n  = 1'b1;
        bus_iorq_n  = 1'b1;
        bus_rd_n    = 1'b1;
        bus_wr_n    = 1'b1;
        cpu_wdata   = '0;
        ext_rdata   = '0;
        mem_rdata   = '0;
        lfsr_q      = LFSR_SEED;
        txn_count   = 0;
        checks_done = 0;
        repeat (RESET_CYCLES) @(posedge bus_clk_3m6);
        #(DRIVE_DELAY);
        bus_reset_n = 1'b1;

        reset_defaults();
        mapper_access();
        exp_readback();
        segment_writes();
        random_layouts();
        idle_cycle(16'h0000);
        idle_cycle(16'h0000);
        @(posedge bus_clk_3m6);
        #(DRIVE_DELAY);

        if (checks_done >= txn_count &&
            u_dut.u_bus_arbiter.u_checker.assert_fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("ERROR: %0d compares for %0d bus cycles, or an assertion failed",
                     checks_done, txn_count);
            $display("Simulation failed");
            $fatal(1, "incomplete run");
        end
    end

    // hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the test hung", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "watchdog timeout");
    end

endmodule
